// ==== branch_unit.f ====
+incdir+include
hw/rv32i_types.sv
hw/predict_hist_tbl.sv
hw/branch_target_buffer.sv
hw/branch_predictor.sv
hw/branch_unit.sv
verification/branch_unit_asserts.sv
verification/tb_branch_unit.sv

// ==== verification/tb_branch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "branch_unit_settings.svh"

module tb_branch_unit
    import rv32i_types::*;
();

    localparam int TAG_LSB     = `BTB_INDEX_WIDTH + 2;
    localparam int BTB_ENTRIES = 1 << `BTB_INDEX_WIDTH;

    logic              clk = 1'b0;
    logic              reset;
    logic [31:0]       fetch_pc;
    logic [31:0]       pc_id;
    rv32i_opcode       opcode_id;
    rv32i_control_word control_word_mem;
    logic              br_en_mem;
    logic [31:0]       alu_out_mem;
    pcmux_sel_t        pcmux_sel;
    logic              flush;
    pred_info_t        pred_info_id;
    logic [31:0]       predict_target;

    // Reference model of history, counters and target buffer.
    logic [`BHR_WIDTH-1:0] m_bhr;
    logic [1:0]            m_pht [1 << `BHR_WIDTH];
    logic                  m_valid [BTB_ENTRIES];
    logic [31:0]           m_tag [BTB_ENTRIES]; // PC bits above the index.
    logic [31:0]           m_target [BTB_ENTRIES];

    int unsigned errors;
    int unsigned checks;
    logic [31:0] loop_pc, loop_tgt, jal_pc, jalr_pc, alias_pc;

    branch_unit u_dut (
        .clk              (clk),
        .reset            (reset),
        .fetch_pc         (fetch_pc),
        .pc_id            (pc_id),
        .opcode_id        (opcode_id),
        .control_word_mem (control_word_mem),
        .br_en_mem        (br_en_mem),
        .alu_out_mem      (alu_out_mem),
        .pcmux_sel        (pcmux_sel),
        .flush            (flush),
        .pred_info_id     (pred_info_id),
        .predict_target   (predict_target)
    );

    always #4 clk = ~clk;

    function automatic logic is_ctrl(input logic [6:0] op);
        return (op == op_br) || (op == op_jal) || (op == op_jalr);
    endfunction

    function automatic rv32i_control_word make_cw(input logic [31:0] pc, input rv32i_opcode op,
                                                  input pred_info_t pred,
                                                  input logic [31:0] pred_target);
        rv32i_control_word cw;
        cw.pc          = pc;
        cw.instr       = {25'd0, op};
        cw.pc_mux_sel  = pc_plus4;
        if (pred.pred_taken) begin
            cw.pc_mux_sel = btb_target;
        end
        cw.pred        = pred;
        cw.pred_target = pred_target;
        return cw;
    endfunction

    task automatic check_eq(input string test, input string what, input logic [63:0] exp,
                            input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL %s: %s expected %0h, actual %0h", test, what, exp, act);
        end
    endtask

    task automatic require(input string test, input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error in %s: %s", test, what);
        end
    endtask

    // IF cycle with an empty MEM stage.
    task automatic fetch(input logic [31:0] pc);
        @(posedge clk);
        fetch_pc         <= pc;
        opcode_id        <= op_imm;
        control_word_mem <= make_cw('0, op_imm, '0, '0);
        br_en_mem        <= 1'b0;
        alu_out_mem      <= '0;
    endtask

    // One cycle with an instruction in ID and one in MEM.
    task automatic run_cycle(input string test, input logic [31:0] id_pc,
                             input rv32i_opcode id_op, input rv32i_control_word cw,
                             input logic br_en, input logic [31:0] alu,
                             output pred_info_t info, output logic [31:0] tgt,
                             output logic flushed);
        int         idx;
        logic       hit, id_taken, mem_ctrl, taken, redirect;
        logic [31:0] target;
        pcmux_sel_t exp_sel;
        pred_info_t exp_info;
        @(posedge clk);
        pc_id            <= id_pc;
        opcode_id        <= id_op;
        control_word_mem <= cw;
        br_en_mem        <= br_en;
        alu_out_mem      <= alu;
        @(negedge clk);
        // ID prediction sees the state before this cycle's update.
        idx      = id_pc[TAG_LSB-1:2];
        hit      = m_valid[idx] && (m_tag[idx] == (id_pc >> TAG_LSB));
        id_taken = is_ctrl(id_op) && m_pht[m_bhr][1] && hit;
        exp_info.pred_taken = id_taken;
        exp_info.pht_index  = m_bhr;
        mem_ctrl = is_ctrl(cw.instr[6:0]);
        taken    = (cw.instr[6:0] == op_br) ? br_en : 1'b1;
        target   = alu;
        if (cw.instr[6:0] == op_jalr) begin
            target[0] = 1'b0;
        end
        redirect = 1'b0;
        exp_sel  = id_taken ? btb_target : pc_plus4;
        if (mem_ctrl && cw.pred.pred_taken && !taken) begin
            redirect = 1'b1;
            exp_sel  = mem_pc_plus4;
        end else if (mem_ctrl && taken && (!cw.pred.pred_taken || cw.pred_target != target)) begin
            redirect = 1'b1;
            exp_sel  = (cw.instr[6:0] == op_jalr) ? alu_mod2 : alu_out;
        end
        check_eq(test, "pred_info_id", exp_info, pred_info_id);
        check_eq(test, "pcmux_sel", exp_sel, pcmux_sel);
        check_eq(test, "flush", redirect, flush);
        if (id_taken) begin
            check_eq(test, "predict_target", m_target[idx], predict_target);
        end
        info    = pred_info_id;
        tgt     = predict_target;
        flushed = flush;
        // Model update for the coming edge.
        if (mem_ctrl) begin
            if (taken && m_pht[cw.pred.pht_index] != 2'b11) begin
                m_pht[cw.pred.pht_index] = m_pht[cw.pred.pht_index] + 2'd1;
            end else if (!taken && m_pht[cw.pred.pht_index] != 2'b00) begin
                m_pht[cw.pred.pht_index] = m_pht[cw.pred.pht_index] - 2'd1;
            end
            m_bhr = {m_bhr[`BHR_WIDTH-2:0], taken};
            if (taken) begin
                idx           = cw.pc[TAG_LSB-1:2];
                m_valid[idx]  = 1'b1;
                m_tag[idx]    = cw.pc >> TAG_LSB;
                m_target[idx] = target;
            end
        end
    endtask

    task automatic predict(input string test, input logic [31:0] pc, input rv32i_opcode op,
                           output pred_info_t info, output logic [31:0] tgt);
        logic flushed;
        fetch(pc);
        run_cycle(test, pc, op, make_cw('0, op_imm, '0, '0), 1'b0, '0, info, tgt, flushed);
    endtask

    task automatic resolve(input string test, input logic [31:0] pc, input rv32i_opcode op,
                           input logic br_en, input logic [31:0] alu, input pred_info_t info,
                           input logic [31:0] tgt, output logic flushed);
        pred_info_t  id_info;
        logic [31:0] id_tgt;
        run_cycle(test, pc, op_imm, make_cw(pc, op, info, tgt), br_en, alu, id_info, id_tgt,
                  flushed);
    endtask

    // Resolve taken until a taken prediction goes through without a flush.
    task automatic train(input string test, input logic [31:0] pc, input rv32i_opcode op,
                         input logic [31:0] target);
        pred_info_t  info;
        logic [31:0] tgt;
        logic        flushed;
        logic        learned;
        int          iter;
        learned = 1'b0;
        iter    = 0;
        while (!learned && iter < 16) begin
            predict(test, pc, op, info, tgt);
            resolve(test, pc, op, 1'b1, target, info, tgt, flushed);
            learned = info.pred_taken && !flushed;
            iter++;
        end
        require(test, learned, $sformatf("no taken prediction at %h after %0d resolutions",
                                         pc, iter));
    endtask

    task automatic reset_state();
        pred_info_t  info;
        logic [31:0] tgt;
        @(negedge clk);
        check_eq("reset_state", "flush", 1'b0, flush);
        check_eq("reset_state", "pcmux_sel", pc_plus4, pcmux_sel);
        predict("reset_state", loop_pc, op_br, info, tgt);
        check_eq("reset_state", "pred_taken", 1'b0, info.pred_taken);
        check_eq("reset_state", "pht_index", '0, info.pht_index);
    endtask

    task automatic taken_then_not_taken();
        pred_info_t  info;
        logic [31:0] tgt;
        logic        flushed;
        predict("not_taken", loop_pc, op_br, info, tgt);
        require("not_taken", info.pred_taken, "trained loop branch was not predicted taken");
        resolve("not_taken", loop_pc, op_br, 1'b0, loop_tgt, info, tgt, flushed);
        require("not_taken", flushed, "wrong taken prediction did not flush");
        fetch(loop_pc);
        @(negedge clk);
        check_eq("not_taken", "pht counter", m_pht[info.pht_index],
                 u_dut.u_predictor.u_pht.pht[info.pht_index]);
    endtask

    task automatic jump_resolution();
        pred_info_t  info;
        logic [31:0] tgt, jalr_old, jalr_new;
        logic        flushed;
        jalr_old = $urandom() & 32'hffff_fffc;
        jalr_new = jalr_old ^ 32'h0000_0100;
        predict("jumps", jal_pc, op_jal, info, tgt);
        require("jumps", !info.pred_taken, "jal predicted taken with an empty buffer entry");
        resolve("jumps", jal_pc, op_jal, 1'b0, $urandom() & 32'hffff_fffc, info, tgt, flushed);
        require("jumps", flushed, "unpredicted jal did not flush");
        train("jumps", jalr_pc, op_jalr, jalr_old);
        predict("jumps", jalr_pc, op_jalr, info, tgt);
        require("jumps", info.pred_taken, "trained jalr was not predicted taken");
        resolve("jumps", jalr_pc, op_jalr, 1'b0, jalr_new | 32'h1, info, tgt, flushed);
        require("jumps", flushed, "jalr to a new target did not flush");
        train("jumps", jalr_pc, op_jalr, jalr_new); // Now resolves to the new target.
    endtask

    task automatic mem_priority();
        pred_info_t  info, jal_info;
        logic [31:0] tgt;
        logic        flushed;
        train("priority", loop_pc, op_br, loop_tgt);
        fetch(loop_pc);
        jal_info.pred_taken = 1'b0;
        jal_info.pht_index  = m_bhr;
        run_cycle("priority", loop_pc, op_br, make_cw(jal_pc, op_jal, jal_info, '0), 1'b0,
                  $urandom() & 32'hffff_fffc, info, tgt, flushed);
        require("priority", info.pred_taken, "loop branch in ID was not predicted taken");
        require("priority", flushed, "MEM redirect lost to the ID prediction");
    endtask

    task automatic buffer_aliasing();
        pred_info_t  info;
        logic [31:0] tgt;
        train("aliasing", alias_pc, op_br, $urandom() & 32'hffff_fffc);
        predict("aliasing", loop_pc, op_br, info, tgt);
        require("aliasing", !info.pred_taken, "evicted branch is still predicted taken");
    endtask

    initial begin
        void'($urandom(86540));
        errors           = 0;
        checks           = 0;
        reset            = 1'b1;
        fetch_pc         = '0;
        pc_id            = '0;
        opcode_id        = op_imm;
        control_word_mem = make_cw('0, op_imm, '0, '0);
        br_en_mem        = 1'b0;
        alu_out_mem      = '0;
        m_bhr            = '0;
        for (int i = 0; i < (1 << `BHR_WIDTH); i++) begin
            m_pht[i] = `PHT_INIT;
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        loop_pc  = $urandom() & 32'hffff_ffe0; // Index 0 of the buffer.
        loop_tgt = $urandom() & 32'hffff_fffc;
        jal_pc   = loop_pc + 32'd4;
        jalr_pc  = loop_pc + 32'd8;
        alias_pc = loop_pc ^ 32'h20;           // Same index, other tag.
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        reset_state();
        train("training", loop_pc, op_br, loop_tgt);
        taken_then_not_taken();
        jump_resolution();
        mem_priority();
        buffer_aliasing();
        fetch(32'h0);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 u_dut.u_asserts.failures);
        if (errors == 0 && u_dut.u_asserts.failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Cycle limit for the whole run.
    initial begin
        repeat (5000) @(posedge clk);
        $display("Timeout: the run did not finish within 5000 cycles");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/branch_unit_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

// Redirect and flush checks on the branch unit.
module branch_unit_asserts
    import rv32i_types::*;
(
    input logic              clk,
    input logic              reset,
    input rv32i_control_word control_word_mem,
    input pcmux_sel_t        pcmux_sel,
    input logic              flush,
    input pred_info_t        pred_info_id
);

    logic redirect_sel;
    logic ctrl_mem;

    int unsigned failures = 0; // Number of failed assertions.

    assign redirect_sel = (pcmux_sel == alu_out) || (pcmux_sel == alu_mod2)
                          || (pcmux_sel == mem_pc_plus4);
    assign ctrl_mem = (control_word_mem.instr[6:0] == op_br)
                      || (control_word_mem.instr[6:0] == op_jal)
                      || (control_word_mem.instr[6:0] == op_jalr);

    flush_has_redirect: assert property (@(posedge clk) disable iff (reset)
        flush |-> redirect_sel)
        else begin
            $error("flush raised while the PC mux is not on a redirect input");
            failures++;
        end

    redirect_has_flush: assert property (@(posedge clk) disable iff (reset)
        redirect_sel |-> flush)
        else begin
            $error("PC mux on a redirect input without a flush");
            failures++;
        end

    flush_needs_ctrl: assert property (@(posedge clk) disable iff (reset)
        flush |-> ctrl_mem)
        else begin
            $error("flush raised with no control-flow instruction in MEM");
            failures++;
        end

    outputs_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({pcmux_sel, flush, pred_info_id}))
        else begin
            $error("unknown value on a branch unit output");
            failures++;
        end

endmodule

bind branch_unit branch_unit_asserts u_asserts (
    .clk              (clk),
    .reset            (reset),
    .control_word_mem (control_word_mem),
    .pcmux_sel        (pcmux_sel),
    .flush            (flush),
    .pred_info_id     (pred_info_id)
);

`default_nettype wire

// ==== hw/branch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

// Branch prediction unit.
// Predictor and target buffer side by side; the pipeline stages are outside.
module branch_unit
    import rv32i_types::*;
(
    input  logic              clk,
    input  logic              reset,

    // IF and ID side.
    input  logic [31:0]       fetch_pc,
    input  logic [31:0]       pc_id,
    input  rv32i_opcode       opcode_id,

    // MEM side.
    input  rv32i_control_word control_word_mem,
    input  logic              br_en_mem,
    input  logic [31:0]       alu_out_mem,

    output pcmux_sel_t        pcmux_sel,
    output logic              flush,
    output pred_info_t        pred_info_id,
    output logic [31:0]       predict_target
);

    logic        btb_hit_id;
    logic [31:0] btb_target_id;
    logic        btb_wr_en;
    logic [31:0] btb_wr_target;

    branch_predictor u_predictor (
        .clk              (clk),
        .reset            (reset),
        .opcode_id        (opcode_id),
        .btb_hit          (btb_hit_id),
        .btb_target       (btb_target_id),
        .control_word_mem (control_word_mem),
        .br_en_mem        (br_en_mem),
        .alu_out_mem      (alu_out_mem),
        .pcmux_sel        (pcmux_sel),
        .flush            (flush),
        .pred_info_id     (pred_info_id),
        .btb_wr_en        (btb_wr_en),
        .btb_wr_target    (btb_wr_target)
    );

    // Written with the PC of the resolving instruction.
    branch_target_buffer u_btb (
        .clk        (clk),
        .reset      (reset),
        .fetch_pc   (fetch_pc),
        .pc_id      (pc_id),
        .wr_en      (btb_wr_en),
        .wr_pc      (control_word_mem.pc),
        .wr_target  (btb_wr_target),
        .btb_hit    (btb_hit_id),
        .btb_target (btb_target_id)
    );

    assign predict_target = btb_target_id; // Feeds the PC mux btb_target input.

endmodule

`default_nettype wire

// ==== hw/branch_predictor.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "branch_unit_settings.svh"

// Global-history predictor.
// Predicts in ID, resolves in MEM, and MEM always wins the PC mux.
module branch_predictor
    import rv32i_types::*;
(
    input  logic              clk,
    input  logic              reset,
    input  rv32i_opcode       opcode_id,
    input  logic              btb_hit,
    input  logic [31:0]       btb_target,
    input  rv32i_control_word control_word_mem,
    input  logic              br_en_mem,
    input  logic [31:0]       alu_out_mem,
    output pcmux_sel_t        pcmux_sel,
    output logic              flush,
    output pred_info_t        pred_info_id,
    output logic              btb_wr_en,
    output logic [31:0]       btb_wr_target
);

    logic [`BHR_WIDTH-1:0] bhr;
    logic [1:0]            pht_counter;
    logic                  is_ctrl_id;
    logic                  pred_taken_id;

    rv32i_opcode           opcode_mem;
    logic                  is_jalr_mem;
    logic                  is_ctrl_mem;
    logic                  actual_taken;
    logic [31:0]           actual_target;
    logic                  redirect;
    pcmux_sel_t            redirect_sel;

    assign is_ctrl_id = (opcode_id == op_br) || (opcode_id == op_jal) || (opcode_id == op_jalr);

    // A misaligned target would trap, so never steer fetch there.
    assign pred_taken_id = is_ctrl_id && pht_counter[1] && btb_hit
                           && (btb_target[1:0] == 2'b00);

    // The table row used here travels with the instruction to MEM.
    always_comb begin
        pred_info_id.pred_taken = pred_taken_id;
        pred_info_id.pht_index  = bhr;
    end

    // MEM decode.
    assign opcode_mem  = rv32i_opcode'(control_word_mem.instr[6:0]);
    assign is_jalr_mem = (opcode_mem == op_jalr);
    assign is_ctrl_mem = (opcode_mem == op_br) || (opcode_mem == op_jal) || is_jalr_mem;

    // Jumps are always taken.
    assign actual_taken = (opcode_mem == op_br) ? br_en_mem : 1'b1;

    always_comb begin
        actual_target = alu_out_mem;
        if (is_jalr_mem) begin
            actual_target[0] = 1'b0;
        end
    end

    // Compare the resolved outcome with what was predicted in ID.
    always_comb begin
        redirect     = 1'b0;
        redirect_sel = pc_plus4;
        if (is_ctrl_mem) begin
            if (control_word_mem.pred.pred_taken && !actual_taken) begin
                redirect     = 1'b1;
                redirect_sel = mem_pc_plus4; // Fall through after all.
            end else if (actual_taken && (!control_word_mem.pred.pred_taken
                         || (control_word_mem.pred_target != actual_target))) begin
                redirect     = 1'b1;
                redirect_sel = is_jalr_mem ? alu_mod2 : alu_out;
            end
        end
    end

    // Resolution first; otherwise the ID guess drives fetch.
    always_comb begin
        if (redirect) begin
            pcmux_sel = redirect_sel;
        end else if (pred_taken_id) begin
            pcmux_sel = rv32i_types::btb_target;
        end else begin
            pcmux_sel = pc_plus4;
        end
    end

    assign flush = redirect;

    // Shift in every resolved outcome.
    always_ff @(posedge clk) begin
        if (reset) begin
            bhr <= '0;
        end else if (is_ctrl_mem) begin
            bhr <= {bhr[`BHR_WIDTH-2:0], actual_taken};
        end
    end

    predict_hist_tbl u_pht (
        .clk       (clk),
        .reset     (reset),
        .rd_index  (bhr),
        .upd_en    (is_ctrl_mem),
        .upd_index (control_word_mem.pred.pht_index),
        .upd_taken (actual_taken),
        .counter   (pht_counter)
    );

    // Only taken outcomes teach the buffer a target.
    assign btb_wr_en     = is_ctrl_mem && actual_taken;
    assign btb_wr_target = actual_target;

endmodule

`default_nettype wire

// ==== hw/branch_target_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "branch_unit_settings.svh"

// Direct-mapped branch target buffer.
// Read address comes in with the fetch PC; the hit is resolved a cycle later in ID.
module branch_target_buffer
    import rv32i_types::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] fetch_pc,
    input  logic [31:0] pc_id,
    input  logic        wr_en,
    input  logic [31:0] wr_pc,
    input  logic [31:0] wr_target,
    output logic        btb_hit,
    output logic [31:0] btb_target
);

    localparam int unsigned NUM_ENTRIES = 1 << `BTB_INDEX_WIDTH;
    localparam int unsigned TAG_LSB     = `BTB_INDEX_WIDTH + 2;

    btb_entry_t                  entries [NUM_ENTRIES];
    btb_entry_t                  rd_entry;   // Entry read for the instruction now in ID.
    btb_entry_t                  wr_entry;
    logic [`BTB_INDEX_WIDTH-1:0] rd_index;
    logic [`BTB_INDEX_WIDTH-1:0] wr_index;

    // Word-aligned PCs, so bits 1:0 carry no index information.
    assign rd_index = fetch_pc[TAG_LSB-1:2];
    assign wr_index = wr_pc[TAG_LSB-1:2];

    always_comb begin
        wr_entry.valid  = 1'b1;
        wr_entry.tag    = wr_pc[31:TAG_LSB];
        wr_entry.target = wr_target;
    end

    // Reset invalidates every entry.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (wr_en) begin
            entries[wr_index] <= wr_entry; // Replaces whatever shared the index.
        end
    end

    // Registered read. A write to the same index this cycle is not seen.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_entry.valid <= 1'b0;
        end else begin
            rd_entry <= entries[rd_index];
        end
    end

    // Tag compare against the PC that reached ID.
    assign btb_hit    = rd_entry.valid && (rd_entry.tag == pc_id[31:TAG_LSB]);
    assign btb_target = rd_entry.target;

endmodule

`default_nettype wire

// ==== hw/predict_hist_tbl.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "branch_unit_settings.svh"

// Pattern history table. One 2-bit saturating counter per history value.
module predict_hist_tbl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`BHR_WIDTH-1:0] rd_index,
    input  logic                  upd_en,
    input  logic [`BHR_WIDTH-1:0] upd_index,
    input  logic                  upd_taken,
    output logic [1:0]            counter
);

    localparam int unsigned NUM_ENTRIES = 1 << `BHR_WIDTH;

    logic [1:0] pht [NUM_ENTRIES];
    logic [1:0] upd_old;
    logic [1:0] upd_new;

    // Combinational read; an update in the same cycle shows up next cycle.
    assign counter = pht[rd_index];
    assign upd_old = pht[upd_index];

    // Step toward the outcome, stick at the ends.
    always_comb begin
        upd_new = upd_old;
        if (upd_taken) begin
            if (upd_old != 2'b11) begin
                upd_new = upd_old + 2'd1;
            end
        end else begin
            if (upd_old != 2'b00) begin
                upd_new = upd_old - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                pht[i] <= `PHT_INIT;
            end
        end else if (upd_en) begin
            pht[upd_index] <= upd_new; // Indexed by the history the branch saw in ID.
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv32i_types.sv ====
`default_nettype none
`include "branch_unit_settings.svh"

package rv32i_types;

    // Opcode field, instr[6:0].
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv32i_opcode;

    // Next-PC source for the fetch stage.
    typedef enum logic [2:0] {
        pc_plus4     = 3'd0, // Sequential fetch.
        alu_out      = 3'd1, // Resolved branch or jal target.
        alu_mod2     = 3'd2, // Resolved jalr target, bit 0 cleared.
        btb_target   = 3'd3, // Predicted taken in ID.
        mem_pc_plus4 = 3'd4  // Undo a wrong taken prediction.
    } pcmux_sel_t;

    // Formed in ID, rides down the pipeline with the instruction.
    typedef struct packed {
        logic                  pred_taken;
        logic [`BHR_WIDTH-1:0] pht_index; // History at prediction time.
    } pred_info_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        pcmux_sel_t  pc_mux_sel;
        pred_info_t  pred;
        logic [31:0] pred_target; // Buffer target seen in ID.
    } rv32i_control_word;

    localparam int unsigned BTB_TAG_WIDTH = 32 - `BTB_INDEX_WIDTH - 2;

    typedef struct packed {
        logic                     valid;
        logic [BTB_TAG_WIDTH-1:0] tag;
        logic [31:0]              target;
    } btb_entry_t;

endpackage

`default_nettype wire

// ==== include/branch_unit_settings.svh ====
`ifndef BRANCH_UNIT_SETTINGS_SVH
`define BRANCH_UNIT_SETTINGS_SVH

// Global history length in resolved control-flow outcomes.
// The pattern table has 2**BHR_WIDTH counters.
`define BHR_WIDTH 4

// Target buffer index bits, taken from the PC just above bit 1.
`define BTB_INDEX_WIDTH 3

// Counter value after reset.
// 2'b01 is weakly not taken, so one taken outcome flips it.
`define PHT_INIT 2'd1

// Counter encoding.
//   2'b00  strongly not taken
//   2'b01  weakly not taken
//   2'b10  weakly taken
//   2'b11  strongly taken

`endif
